// ==== src/wbSram_macros.svh ====
`ifndef WBSRAM_MACROS_SVH
`define WBSRAM_MACROS_SVH

// wishbone bus widths.
`define WB_ADDR_WIDTH 24
`define WB_DATA_WIDTH 32
`define WB_SEL_WIDTH (`WB_DATA_WIDTH / 8)

// byte address width inside one region.
`define PERIPH_ADDR_WIDTH 20

// local sram geometry and timing.
`define SRAM_DEPTH 256
`define SRAM_WAIT_STATES 2

// value of adr[23:20] for the management block.
`define MGMT_REGION 4'h8

`endif

// ==== src/wbSramPkg.sv ====
`include "wbSram_macros.svh"

package wbSramPkg;

	// request driven by the bus interface to each target.
	typedef struct packed {
		logic writeEnable;
		logic readEnable;
		logic [`WB_SEL_WIDTH-1:0] byteSelect;
		logic [`PERIPH_ADDR_WIDTH-1:0] address;
		logic [`WB_DATA_WIDTH-1:0] writeData;
	} peripheralReq_t;

	// response returned by each target.
	typedef struct packed {
		logic [`WB_DATA_WIDTH-1:0] readData;
		logic busy;
	} peripheralRsp_t;

	// merge only the selected bytes of newWord into oldWord.
	function automatic logic [`WB_DATA_WIDTH-1:0] applyByteSelect(
		input logic [`WB_DATA_WIDTH-1:0] oldWord,
		input logic [`WB_DATA_WIDTH-1:0] newWord,
		input logic [`WB_SEL_WIDTH-1:0] byteSelect
	);
		logic [`WB_DATA_WIDTH-1:0] merged;
		merged = oldWord;
		for (int i = 0; i < `WB_SEL_WIDTH; i++) begin
			if (byteSelect[i]) begin
				merged[8*i +: 8] = newWord[8*i +: 8];
			end
		end
		return merged;
	endfunction

endpackage

// ==== src/wbSramInterface.sv ====
`timescale 1ns/1ps
`include "wbSram_macros.svh"

module wbSramInterface (
	input  logic                      wb_clk_i,
	input  logic                      wb_rst_i,
	input  logic                      wbCyc_i,
	input  logic                      wbStb_i,
	input  logic                      wbWe_i,
	input  logic [`WB_SEL_WIDTH-1:0]  wbSel_i,
	input  logic [`WB_ADDR_WIDTH-1:0] wbAdr_i,
	input  logic [`WB_DATA_WIDTH-1:0] wbData_i,
	output logic                      wbAck_o,
	output logic                      wbStall_o,
	output logic                      wbError_o,
	output logic [`WB_DATA_WIDTH-1:0] wbData_o,
	output wbSramPkg::peripheralReq_t sramReq_o,
	output wbSramPkg::peripheralReq_t mgmtReq_o,
	input  wbSramPkg::peripheralRsp_t sramRsp_i,
	input  wbSramPkg::peripheralRsp_t mgmtRsp_i
);
	import wbSramPkg::*;

	typedef enum logic [1:0] {
		StateIdle,
		StateRequest,
		StateError,
		StateFinish
	} wbState_t;

	wbState_t state;
	logic [`WB_ADDR_WIDTH-1:0] currentAddress;
	logic [`WB_SEL_WIDTH-1:0] currentSel;
	logic [`WB_DATA_WIDTH-1:0] currentData;
	logic currentWrite;
	logic ackReg;
	logic errorReg;
	logic [`WB_DATA_WIDTH-1:0] readDataReg;
	logic requestSeen;
	logic sramSelected;
	logic mgmtSelected;
	logic targetBusy;
	logic [`WB_DATA_WIDTH-1:0] targetReadData;
	peripheralReq_t baseReq;

	function automatic logic isSramRegion(input logic [`WB_ADDR_WIDTH-1:0] adr);
		return adr[`WB_ADDR_WIDTH-1] == 1'b0;
	endfunction

	function automatic logic isMgmtRegion(input logic [`WB_ADDR_WIDTH-1:0] adr);
		return adr[`WB_ADDR_WIDTH-1:`PERIPH_ADDR_WIDTH] == `MGMT_REGION;
	endfunction

	assign requestSeen = (state == StateIdle) && wbCyc_i && wbStb_i;

	// request fields are held for the whole transfer.
	always_ff @(posedge wb_clk_i) begin
		if (requestSeen) begin
			currentAddress <= wbAdr_i;
			currentSel <= wbSel_i;
			currentData <= wbData_i;
			currentWrite <= wbWe_i;
		end
	end

	// target choice comes from the held address.
	assign sramSelected = isSramRegion(currentAddress);
	assign mgmtSelected = isMgmtRegion(currentAddress);

	always_comb begin
		if (sramSelected) begin
			targetBusy = sramRsp_i.busy;
			targetReadData = sramRsp_i.readData;
		end else if (mgmtSelected) begin
			targetBusy = mgmtRsp_i.busy;
			targetReadData = mgmtRsp_i.readData;
		end else begin
			targetBusy = 1'b0;
			targetReadData = '0;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state <= StateIdle;
			ackReg <= 1'b0;
			errorReg <= 1'b0;
			readDataReg <= '0;
		end else begin
			ackReg <= 1'b0;
			errorReg <= 1'b0;
			case (state)
				StateIdle: begin
					if (requestSeen) begin
						// unmapped addresses never reach a target.
						if (isSramRegion(wbAdr_i) || isMgmtRegion(wbAdr_i)) begin
							state <= StateRequest;
						end else begin
							state <= StateError;
						end
					end
				end
				StateRequest: begin
					if (!targetBusy) begin
						ackReg <= 1'b1;
						if (!currentWrite) begin
							readDataReg <= targetReadData;
						end
						state <= StateFinish;
					end
				end
				StateError: begin
					errorReg <= 1'b1;
					state <= StateFinish;
				end
				StateFinish: begin
					readDataReg <= '0;
					state <= StateIdle;
				end
				default: begin
					state <= StateIdle;
				end
			endcase
		end
	end

	always_comb begin
		baseReq.writeEnable = (state == StateRequest) && currentWrite;
		baseReq.readEnable = (state == StateRequest) && !currentWrite;
		baseReq.byteSelect = currentSel;
		baseReq.address = currentAddress[`PERIPH_ADDR_WIDTH-1:0];
		baseReq.writeData = currentData;

		sramReq_o = baseReq;
		sramReq_o.writeEnable = baseReq.writeEnable && sramSelected;
		sramReq_o.readEnable = baseReq.readEnable && sramSelected;

		mgmtReq_o = baseReq;
		mgmtReq_o.writeEnable = baseReq.writeEnable && mgmtSelected;
		mgmtReq_o.readEnable = baseReq.readEnable && mgmtSelected;
	end

	assign wbAck_o = ackReg;
	assign wbError_o = errorReg;
	assign wbData_o = readDataReg;
	assign wbStall_o = state != StateIdle;

endmodule

// ==== src/localSram.sv ====
`timescale 1ns/1ps
`include "wbSram_macros.svh"

module localSram (
	input  logic                      wb_clk_i,
	input  logic                      wb_rst_i,
	input  wbSramPkg::peripheralReq_t req_i,
	output wbSramPkg::peripheralRsp_t rsp_o
);
	import wbSramPkg::*;

	localparam int WordBits = $clog2(`SRAM_DEPTH);
	localparam int CountBits = $clog2(`SRAM_WAIT_STATES + 2);
	localparam logic [CountBits-1:0] WaitLimit = CountBits'(`SRAM_WAIT_STATES);

	logic [`WB_DATA_WIDTH-1:0] memory [`SRAM_DEPTH];
	logic [CountBits-1:0] waitCount;
	logic [WordBits-1:0] wordIndex;
	logic accessActive;
	logic busy;

	assign accessActive = req_i.writeEnable || req_i.readEnable;

	// upper region bits alias onto the same word.
	assign wordIndex = req_i.address[WordBits+1:2];

	assign busy = accessActive && (waitCount != WaitLimit);

	// counts wait states, rearms once the enables drop.
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			waitCount <= '0;
		end else if (!accessActive) begin
			waitCount <= '0;
		end else if (busy) begin
			waitCount <= waitCount + 1'b1;
		end
	end

	// write lands on the cycle busy is low.
	always_ff @(posedge wb_clk_i) begin
		if (req_i.writeEnable && !busy) begin
			memory[wordIndex] <= applyByteSelect(memory[wordIndex], req_i.writeData,
				req_i.byteSelect);
		end
	end

	always_comb begin
		rsp_o.busy = busy;
		if (req_i.readEnable && !busy) begin
			rsp_o.readData = memory[wordIndex];
		end else begin
			rsp_o.readData = '0;
		end
	end

endmodule

// ==== src/managementRegs.sv ====
`timescale 1ns/1ps
`include "wbSram_macros.svh"

module managementRegs (
	input  logic                      wb_clk_i,
	input  logic                      wb_rst_i,
	input  logic [3:0]                coreId_i,
	input  wbSramPkg::peripheralReq_t req_i,
	output wbSramPkg::peripheralRsp_t rsp_o
);
	import wbSramPkg::*;

	localparam int OffsetBits = `PERIPH_ADDR_WIDTH - 2;

	logic [OffsetBits-1:0] wordOffset;
	logic [`WB_DATA_WIDTH-1:0] scratchReg1;
	logic [`WB_DATA_WIDTH-1:0] scratchReg2;
	logic [`WB_DATA_WIDTH-1:0] selectedWord;

	assign wordOffset = req_i.address[`PERIPH_ADDR_WIDTH-1:2];

	// word 0 is read only.
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			scratchReg1 <= '0;
			scratchReg2 <= '0;
		end else if (req_i.writeEnable) begin
			if (wordOffset == OffsetBits'(1)) begin
				scratchReg1 <= applyByteSelect(scratchReg1, req_i.writeData, req_i.byteSelect);
			end
			if (wordOffset == OffsetBits'(2)) begin
				scratchReg2 <= applyByteSelect(scratchReg2, req_i.writeData, req_i.byteSelect);
			end
		end
	end

	always_comb begin
		selectedWord = '0;
		case (wordOffset)
			OffsetBits'(0): selectedWord[3:0] = coreId_i;
			OffsetBits'(1): selectedWord = scratchReg1;
			OffsetBits'(2): selectedWord = scratchReg2;
			default: selectedWord = '0;
		endcase
	end

	// always answers in the same cycle.
	always_comb begin
		rsp_o.busy = 1'b0;
		if (req_i.readEnable) begin
			rsp_o.readData = selectedWord;
		end else begin
			rsp_o.readData = '0;
		end
	end

endmodule

// ==== src/wbSramSubsystem.sv ====
`timescale 1ns/1ps
`include "wbSram_macros.svh"

module wbSramSubsystem (
	input  logic                      wb_clk_i,
	input  logic                      wb_rst_i,
	input  logic                      wbCyc_i,
	input  logic                      wbStb_i,
	input  logic                      wbWe_i,
	input  logic [`WB_SEL_WIDTH-1:0]  wbSel_i,
	input  logic [`WB_ADDR_WIDTH-1:0] wbAdr_i,
	input  logic [`WB_DATA_WIDTH-1:0] wbData_i,
	output logic                      wbAck_o,
	output logic                      wbStall_o,
	output logic                      wbError_o,
	output logic [`WB_DATA_WIDTH-1:0] wbData_o,
	input  logic [3:0]                coreId_i
);
	import wbSramPkg::*;

	peripheralReq_t sramReq;
	peripheralReq_t mgmtReq;
	peripheralRsp_t sramRsp;
	peripheralRsp_t mgmtRsp;

	wbSramInterface busInterface (
		.wb_clk_i  (wb_clk_i),
		.wb_rst_i  (wb_rst_i),
		.wbCyc_i   (wbCyc_i),
		.wbStb_i   (wbStb_i),
		.wbWe_i    (wbWe_i),
		.wbSel_i   (wbSel_i),
		.wbAdr_i   (wbAdr_i),
		.wbData_i  (wbData_i),
		.wbAck_o   (wbAck_o),
		.wbStall_o (wbStall_o),
		.wbError_o (wbError_o),
		.wbData_o  (wbData_o),
		.sramReq_o (sramReq),
		.mgmtReq_o (mgmtReq),
		.sramRsp_i (sramRsp),
		.mgmtRsp_i (mgmtRsp)
	);

	localSram sram (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.req_i    (sramReq),
		.rsp_o    (sramRsp)
	);

	managementRegs mgmt (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.coreId_i (coreId_i),
		.req_i    (mgmtReq),
		.rsp_o    (mgmtRsp)
	);

endmodule

// ==== tests/wbSramProperties.sv ====
`timescale 1ns/1ps
`include "wbSram_macros.svh"

module wbSramProperties (
	input logic                      wb_clk_i,
	input logic                      wb_rst_i,
	input logic                      wbCyc_i,
	input logic                      wbStb_i,
	input logic [`WB_ADDR_WIDTH-1:0] wbAdr_i,
	input logic                      wbAck_i,
	input logic                      wbStall_i,
	input logic                      wbError_i
);
	logic captureSeen;
	logic mgmtCapture;
	logic responseSeen;

	assign captureSeen = wbCyc_i && wbStb_i && !wbStall_i;
	assign mgmtCapture = captureSeen &&
		(wbAdr_i[`WB_ADDR_WIDTH-1:`PERIPH_ADDR_WIDTH] == `MGMT_REGION);
	assign responseSeen = wbAck_i || wbError_i;

	resetClears: assert property (@(posedge wb_clk_i)
		wb_rst_i |=> (!wbAck_i && !wbStall_i && !wbError_i))
		else $error("ack, stall or error high after reset");

	ackErrorExclusive: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		!(wbAck_i && wbError_i))
		else $error("ack and error high together");

	responseOneCycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		responseSeen |=> !responseSeen)
		else $error("ack or error held longer than one cycle");

	// stall rises after capture and only falls after the finish cycle.
	stallAfterCapture: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		captureSeen |=> wbStall_i)
		else $error("stall low after a request was captured");

	stallDuringFinish: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		responseSeen |-> wbStall_i)
		else $error("stall low during the response cycle");

	stallFallsAfterResponse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		$fell(wbStall_i) |-> $past(responseSeen))
		else $error("stall dropped before the transfer finished");

	mgmtLatency: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		$past(mgmtCapture, 2) |-> wbAck_i)
		else $error("management access not acknowledged two cycles after its request");

endmodule

// ==== tests/wbSramChecker.sv ====
`timescale 1ns/1ps
`include "wbSram_macros.svh"

module wbSramChecker (
	input  logic                      wb_clk_i,
	input  logic                      wb_rst_i,
	input  logic                      wbCyc_i,
	input  logic                      wbStb_i,
	input  logic                      wbWe_i,
	input  logic [`WB_SEL_WIDTH-1:0]  wbSel_i,
	input  logic [`WB_ADDR_WIDTH-1:0] wbAdr_i,
	input  logic [`WB_DATA_WIDTH-1:0] wbDataWrite_i,
	input  logic [`WB_DATA_WIDTH-1:0] wbDataRead_i,
	input  logic                      wbAck_i,
	input  logic                      wbStall_i,
	input  logic                      wbError_i,
	input  logic [3:0]                coreId_i,
	input  logic                      expectError_i,
	output int                        errorCount_o
);
	logic [`WB_DATA_WIDTH-1:0] sramModel [`SRAM_DEPTH];
	logic [`WB_DATA_WIDTH-1:0] scratchModel [1:2];
	logic pending;
	logic pendWrite;
	logic pendExpectError;
	logic [`WB_ADDR_WIDTH-1:0] pendAdr;
	logic [`WB_SEL_WIDTH-1:0] pendSel;
	logic [`WB_DATA_WIDTH-1:0] pendData;

	// new word from old word, data and byte selects.
	function automatic logic [`WB_DATA_WIDTH-1:0] maskedWord(
		input logic [`WB_DATA_WIDTH-1:0] oldWord,
		input logic [`WB_DATA_WIDTH-1:0] data,
		input logic [`WB_SEL_WIDTH-1:0] sel
	);
		logic [`WB_DATA_WIDTH-1:0] mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (oldWord & ~mask) | (data & mask);
	endfunction

	task automatic checkResponse();
		logic [`WB_DATA_WIDTH-1:0] expected;
		if (wbError_i !== pendExpectError || wbAck_i !== !pendExpectError) begin
			$display("mismatch wbError_o at adr %h: got %h expected %h",
				pendAdr, wbError_i, pendExpectError);
			errorCount_o++;
		end
		expected = '0;
		if (!pendExpectError && !pendAdr[23]) begin
			expected = sramModel[pendAdr[9:2]];
			if (pendWrite) begin
				sramModel[pendAdr[9:2]] = maskedWord(expected, pendData, pendSel);
			end
		end else if (!pendExpectError) begin
			case (pendAdr[19:2])
				18'd0: expected = {28'd0, coreId_i};
				18'd1: expected = scratchModel[1];
				18'd2: expected = scratchModel[2];
				default: expected = '0;
			endcase
			if (pendWrite && (pendAdr[19:2] == 18'd1 || pendAdr[19:2] == 18'd2)) begin
				scratchModel[pendAdr[3:2]] = maskedWord(expected, pendData, pendSel);
			end
		end
		// writes return no data, errors return zero.
		if (pendWrite && !pendExpectError) begin
			expected = '0;
		end
		if (wbDataRead_i !== expected) begin
			$display("mismatch wbData_o at adr %h: got %h expected %h",
				pendAdr, wbDataRead_i, expected);
			errorCount_o++;
		end
	endtask

	always @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			pending = 1'b0;
			errorCount_o = 0;
			scratchModel[1] = '0;
			scratchModel[2] = '0;
		end else begin
			if (wbAck_i || wbError_i) begin
				if (pending) begin
					checkResponse();
				end else begin
					$display("response seen with no request outstanding");
					errorCount_o++;
				end
				pending = 1'b0;
			end
			if (wbCyc_i && wbStb_i && !wbStall_i) begin
				pending = 1'b1;
				pendWrite = wbWe_i;
				pendAdr = wbAdr_i;
				pendSel = wbSel_i;
				pendData = wbDataWrite_i;
				pendExpectError = expectError_i;
			end
		end
	end

endmodule

// ==== tests/wbSramTb.sv ====
`timescale 1ns/1ps
`include "wbSram_macros.svh"

module wbSramTb;
	typedef struct packed {
		logic isWrite;
		logic [`WB_ADDR_WIDTH-1:0] address;
		logic [`WB_SEL_WIDTH-1:0] select;
		logic [`WB_DATA_WIDTH-1:0] data;
		logic expectError;
	} access_t;

	localparam int StepLimit = 20;

	logic wb_clk_i;
	logic wb_rst_i;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [`WB_SEL_WIDTH-1:0] wbSel;
	logic [`WB_ADDR_WIDTH-1:0] wbAdr;
	logic [`WB_DATA_WIDTH-1:0] wbDataWrite;
	logic [`WB_DATA_WIDTH-1:0] wbDataRead;
	logic wbAck;
	logic wbStall;
	logic wbError;
	logic [3:0] coreId;
	logic expectError;
	int checkErrors;
	int timeoutCount;
	access_t accessTable[$];

	wbSramSubsystem UUT (
		.wb_clk_i  (wb_clk_i),
		.wb_rst_i  (wb_rst_i),
		.wbCyc_i   (wbCyc),
		.wbStb_i   (wbStb),
		.wbWe_i    (wbWe),
		.wbSel_i   (wbSel),
		.wbAdr_i   (wbAdr),
		.wbData_i  (wbDataWrite),
		.wbAck_o   (wbAck),
		.wbStall_o (wbStall),
		.wbError_o (wbError),
		.wbData_o  (wbDataRead),
		.coreId_i  (coreId)
	);

	wbSramChecker responseCheck (
		.wb_clk_i      (wb_clk_i),
		.wb_rst_i      (wb_rst_i),
		.wbCyc_i       (wbCyc),
		.wbStb_i       (wbStb),
		.wbWe_i        (wbWe),
		.wbSel_i       (wbSel),
		.wbAdr_i       (wbAdr),
		.wbDataWrite_i (wbDataWrite),
		.wbDataRead_i  (wbDataRead),
		.wbAck_i       (wbAck),
		.wbStall_i     (wbStall),
		.wbError_i     (wbError),
		.coreId_i      (coreId),
		.expectError_i (expectError),
		.errorCount_o  (checkErrors)
	);

	bind wbSramInterface wbSramProperties handshakeProps (
		.wb_clk_i  (wb_clk_i),
		.wb_rst_i  (wb_rst_i),
		.wbCyc_i   (wbCyc_i),
		.wbStb_i   (wbStb_i),
		.wbAdr_i   (wbAdr_i),
		.wbAck_i   (wbAck_o),
		.wbStall_i (wbStall_o),
		.wbError_i (wbError_o)
	);

	initial begin
		wb_clk_i = 1'b0;
		forever begin
			#2 wb_clk_i = ~wb_clk_i;
		end
	end

	task automatic addAccess(input logic isWrite, input logic [`WB_ADDR_WIDTH-1:0] address,
		input logic [`WB_SEL_WIDTH-1:0] select, input logic [`WB_DATA_WIDTH-1:0] data,
		input logic expectErr);
		accessTable.push_back({isWrite, address, select, data, expectErr});
	endtask

	task automatic buildTable();
		logic [`WB_DATA_WIDTH-1:0] rnd [4];
		foreach (rnd[i]) begin
			rnd[i] = $urandom();
		end
		// sram words, then the same words through aliased addresses.
		addAccess(1'b1, 24'h000010, 4'hF, rnd[0], 1'b0);
		addAccess(1'b1, 24'h000020, 4'hF, rnd[1], 1'b0);
		addAccess(1'b1, 24'h0003FC, 4'hF, rnd[2], 1'b0);
		addAccess(1'b0, 24'h000010, 4'hF, '0, 1'b0);
		addAccess(1'b0, 24'h000410, 4'hF, '0, 1'b0);
		addAccess(1'b0, 24'h4F0020, 4'hF, '0, 1'b0);
		addAccess(1'b0, 24'h0003FC, 4'hF, '0, 1'b0);
		addAccess(1'b1, 24'h7FFC10, 4'hF, rnd[3], 1'b0);
		addAccess(1'b0, 24'h000010, 4'hF, '0, 1'b0);
		// partial byte writes.
		addAccess(1'b1, 24'h000020, 4'b0101, 32'hA5A5_A5A5, 1'b0);
		addAccess(1'b0, 24'h000020, 4'hF, '0, 1'b0);
		addAccess(1'b1, 24'h800004, 4'hF, 32'h1122_3344, 1'b0);
		addAccess(1'b1, 24'h800004, 4'b1000, 32'hFF00_0000, 1'b0);
		addAccess(1'b0, 24'h800004, 4'hF, '0, 1'b0);
		addAccess(1'b1, 24'h800008, 4'b0011, 32'hDEAD_BEEF, 1'b0);
		addAccess(1'b0, 24'h800008, 4'hF, '0, 1'b0);
		// core id is read only.
		addAccess(1'b0, 24'h800000, 4'hF, '0, 1'b0);
		addAccess(1'b1, 24'h800000, 4'hF, 32'hFFFF_FFFF, 1'b0);
		addAccess(1'b0, 24'h800000, 4'hF, '0, 1'b0);
		addAccess(1'b0, 24'h80000C, 4'hF, '0, 1'b0);
		addAccess(1'b0, 24'h8FFFF0, 4'hF, '0, 1'b0);
		// unmapped regions must not touch either target.
		addAccess(1'b1, 24'h900010, 4'hF, 32'h0BAD_0BAD, 1'b1);
		addAccess(1'b1, 24'hC00020, 4'hF, 32'h0BAD_0BAD, 1'b1);
		addAccess(1'b0, 24'hA00000, 4'hF, '0, 1'b1);
		addAccess(1'b1, 24'hF80004, 4'hF, 32'h0BAD_0BAD, 1'b1);
		addAccess(1'b0, 24'h000020, 4'hF, '0, 1'b0);
		addAccess(1'b0, 24'h800004, 4'hF, '0, 1'b0);
		addAccess(1'b0, 24'h000010, 4'hF, '0, 1'b0);
	endtask

	task automatic waitForIdle();
		int steps;
		steps = 0;
		while (wbStall && steps < StepLimit) begin
			@(negedge wb_clk_i);
			steps++;
		end
		if (wbStall) begin
			$display("timeout: stall stayed high for %0d cycles", StepLimit);
			timeoutCount++;
		end
	endtask

	task automatic applyAccess(input access_t entry);
		int steps;
		waitForIdle();
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = entry.isWrite;
		wbAdr = entry.address;
		wbSel = entry.select;
		wbDataWrite = entry.data;
		expectError = entry.expectError;
		@(negedge wb_clk_i);
		wbStb = 1'b0;
		steps = 0;
		while (!(wbAck || wbError) && steps < StepLimit) begin
			@(negedge wb_clk_i);
			steps++;
		end
		if (!(wbAck || wbError)) begin
			$display("timeout: no ack or error for address %h", entry.address);
			timeoutCount++;
		end
		wbCyc = 1'b0;
	endtask

	initial begin
		wb_rst_i = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbSel = '0;
		wbAdr = '0;
		wbDataWrite = '0;
		coreId = 4'hB;
		expectError = 1'b0;
		timeoutCount = 0;
		void'($urandom(32'h0044_e31d));
		buildTable();
		repeat (3) @(posedge wb_clk_i);
		@(negedge wb_clk_i);
		wb_rst_i = 1'b0;
		foreach (accessTable[i]) begin
			applyAccess(accessTable[i]);
		end
		// let the checker see the last response.
		repeat (2) @(negedge wb_clk_i);
		$display("errors: %0d mismatches, %0d timeouts", checkErrors, timeoutCount);
		if (checkErrors == 0 && timeoutCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+src
src/wbSramPkg.sv
src/wbSramInterface.sv
src/localSram.sv
src/managementRegs.sv
src/wbSramSubsystem.sv
tests/wbSramProperties.sv
tests/wbSramChecker.sv
tests/wbSramTb.sv

// ==== Makefile ====
BIN := obj_dir/VwbSramTb
SOURCES := $(filter-out +%,$(shell cat sim.f)) src/wbSram_macros.svh

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

$(BIN): sim.f $(SOURCES)
	verilator --binary --assert --timing -j 0 --top-module wbSramTb -f sim.f

clean:
	rm -rf obj_dir
